// ==== all.f ====
logic/csr_pkg.sv
logic/csr_decode.sv
logic/csr_alu.sv
logic/csr_file.sv
logic/csr_unit.sv
tests/tb_clock.sv
tests/tb_csr_unit.sv

// ==== logic/csr_alu.sv ====
// read-modify-write value for csrrw, csrrs and csrrc and their immediate forms
`timescale 1ns/1ps

module csr_alu (
  input  csr_pkg::csr_op_e op,
  input  logic [31:0]      old_value,
  input  logic [31:0]      operand,
  input  logic             no_write,
  output logic [31:0]      new_value,
  output logic             write_en
);

  logic is_csr_op;

  always_comb begin
    is_csr_op = 1'b1;
    case (op)
      csr_pkg::op_write: begin
        new_value = operand;
      end
      csr_pkg::op_set: begin
        new_value = old_value | operand;
      end
      csr_pkg::op_clear: begin
        new_value = old_value & ~operand;
      end
      default: begin
        // ecall, mret and illegal leave the CSR alone
        new_value = old_value;
        is_csr_op = 1'b0;
      end
    endcase
  end

  // csrrs/csrrc with rs1 = x0 only read
  assign write_en = is_csr_op && !no_write;

endmodule

// ==== logic/csr_decode.sv ====
// stage 1 decoder for SYSTEM instructions into a registered CSR request
`timescale 1ns/1ps

module csr_decode (
  input  logic               clk,
  input  logic               reset_x,
  input  logic               instr_valid,
  input  logic [31:0]        instr,
  input  logic [31:0]        pc,
  input  logic [31:0]        rs1_data,
  input  logic               squash,
  output csr_pkg::csr_req_t  req
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [4:0]        rs1_field;
  logic [11:0]       addr;
  logic              known_addr;
  csr_pkg::csr_op_e  op_d;
  logic [31:0]       operand_d;
  logic              no_write_d;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign rs1_field = instr[19:15];
  assign addr      = instr[31:20];

  // only the eight implemented CSRs are legal targets
  always_comb begin
    case (addr)
      csr_pkg::csr_addr_mstatus,
      csr_pkg::csr_addr_mie,
      csr_pkg::csr_addr_mtvec,
      csr_pkg::csr_addr_mscratch,
      csr_pkg::csr_addr_mepc,
      csr_pkg::csr_addr_mcause,
      csr_pkg::csr_addr_mtval,
      csr_pkg::csr_addr_mip:   known_addr = 1'b1;
      default:                 known_addr = 1'b0;
    endcase
  end

  always_comb begin
    op_d = csr_pkg::op_illegal;
    if (opcode == csr_pkg::opcode_system) begin
      case (funct3)
        3'b001, 3'b101: op_d = known_addr ? csr_pkg::op_write : csr_pkg::op_illegal;
        3'b010, 3'b110: op_d = known_addr ? csr_pkg::op_set : csr_pkg::op_illegal;
        3'b011, 3'b111: op_d = known_addr ? csr_pkg::op_clear : csr_pkg::op_illegal;
        3'b000: begin
          if (instr == csr_pkg::instr_ecall) begin
            op_d = csr_pkg::op_ecall;
          end else if (instr == csr_pkg::instr_mret) begin
            op_d = csr_pkg::op_mret;
          end
        end
        default: op_d = csr_pkg::op_illegal;
      endcase
    end
    // immediate forms carry uimm in the rs1 field
    operand_d  = funct3[2] ? {27'd0, rs1_field} : rs1_data;
    no_write_d = (op_d == csr_pkg::op_set || op_d == csr_pkg::op_clear) &&
                 (rs1_field == 5'd0);
  end

  always_ff @(posedge clk) begin
    if (!reset_x) begin
      req.valid <= 1'b0;
    end else begin
      // drop the instruction behind a trap or mret
      req.valid <= instr_valid && !squash;
    end
    if (instr_valid) begin
      req.op       <= op_d;
      req.addr     <= addr;
      req.operand  <= operand_d;
      req.no_write <= no_write_d;
      req.rd       <= instr[11:7];
      req.pc       <= pc;
      req.instr    <= instr;
    end
  end

  a_priv_op_is_system: assert property (@(posedge clk) disable iff (!reset_x)
    req.valid && (req.op == csr_pkg::op_ecall || req.op == csr_pkg::op_mret)
    |-> req.instr[6:0] == csr_pkg::opcode_system)
    else $error("ecall/mret decoded from a non-SYSTEM opcode");

endmodule

// ==== logic/csr_file.sv ====
// stage 2 CSR storage, privilege mode, trap entry, mret and output registers
`timescale 1ns/1ps

module csr_file (
  input  logic                   clk,
  input  logic                   reset_x,
  input  csr_pkg::csr_req_t      req,
  input  logic [31:0]            new_value,
  input  logic                   write_en,
  output logic [31:0]            old_value,
  output csr_pkg::csr_result_t   result,
  output csr_pkg::csr_redirect_t redirect,
  output logic                   squash,
  output csr_pkg::priv_e         priv_mode
);

  logic [31:0] mstatus;
  logic [31:0] mie;
  logic [31:0] mtvec;
  logic [31:0] mscratch;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic [31:0] mtval;
  logic [31:0] mip;

  logic        is_csr_op;
  logic        illegal;
  logic        trap;
  logic        do_mret;
  logic        do_csr;
  logic [3:0]  trap_cause;

  // read port, unknown addresses never reach a commit
  always_comb begin
    case (req.addr)
      csr_pkg::csr_addr_mstatus:  old_value = mstatus;
      csr_pkg::csr_addr_mie:      old_value = mie;
      csr_pkg::csr_addr_mtvec:    old_value = mtvec;
      csr_pkg::csr_addr_mscratch: old_value = mscratch;
      csr_pkg::csr_addr_mepc:     old_value = mepc;
      csr_pkg::csr_addr_mcause:   old_value = mcause;
      csr_pkg::csr_addr_mtval:    old_value = mtval;
      csr_pkg::csr_addr_mip:      old_value = mip;
      default:                    old_value = 32'd0;
    endcase
  end

  always_comb begin
    is_csr_op = req.op == csr_pkg::op_write || req.op == csr_pkg::op_set ||
                req.op == csr_pkg::op_clear;
    // all implemented CSRs sit in 0x3xx, so U mode may touch none of them
    illegal = req.op == csr_pkg::op_illegal ||
              ((is_csr_op || req.op == csr_pkg::op_mret) && priv_mode == csr_pkg::priv_u);
    trap    = req.valid && (illegal || req.op == csr_pkg::op_ecall);
    do_mret = req.valid && !illegal && req.op == csr_pkg::op_mret;
    do_csr  = req.valid && !illegal && is_csr_op;
    if (illegal) begin
      trap_cause = csr_pkg::cause_illegal;
    end else if (priv_mode == csr_pkg::priv_m) begin
      trap_cause = csr_pkg::cause_ecall_m;
    end else begin
      trap_cause = csr_pkg::cause_ecall_u;
    end
  end

  assign squash = trap || do_mret;

  always_ff @(posedge clk) begin
    if (!reset_x) begin
      mstatus   <= csr_pkg::mstatus_reset;
      mie       <= 32'd0;
      mtvec     <= 32'd0;
      mscratch  <= csr_pkg::mscratch_reset;
      mepc      <= 32'd0;
      mcause    <= 32'd0;
      mtval     <= 32'd0;
      mip       <= 32'd0;
      priv_mode <= csr_pkg::priv_m;
    end else if (trap) begin
      mepc   <= req.pc;
      mcause <= {28'd0, trap_cause};
      // mtval only holds the faulting word for illegal instructions
      if (illegal) begin
        mtval <= req.instr;
      end
      mstatus[csr_pkg::mstatus_mpie]      <= mstatus[csr_pkg::mstatus_mie];
      mstatus[csr_pkg::mstatus_mie]       <= 1'b0;
      mstatus[csr_pkg::mstatus_mpp_lo +: 2] <= priv_mode;
      priv_mode <= csr_pkg::priv_m;
    end else if (do_mret) begin
      mstatus[csr_pkg::mstatus_mie]       <= mstatus[csr_pkg::mstatus_mpie];
      mstatus[csr_pkg::mstatus_mpie]      <= 1'b1;
      mstatus[csr_pkg::mstatus_mpp_lo +: 2] <= csr_pkg::priv_u;
      priv_mode <= csr_pkg::priv_e'(mstatus[csr_pkg::mstatus_mpp_lo +: 2]);
    end else if (do_csr && write_en) begin
      case (req.addr)
        csr_pkg::csr_addr_mstatus:  mstatus  <= new_value;
        csr_pkg::csr_addr_mie:      mie      <= new_value;
        csr_pkg::csr_addr_mtvec:    mtvec    <= new_value;
        csr_pkg::csr_addr_mscratch: mscratch <= new_value;
        csr_pkg::csr_addr_mepc:     mepc     <= new_value;
        csr_pkg::csr_addr_mcause:   mcause   <= new_value;
        csr_pkg::csr_addr_mtval:    mtval    <= new_value;
        csr_pkg::csr_addr_mip:      mip      <= new_value;
        default: ;
      endcase
    end
  end

  // one-cycle output pulses
  always_ff @(posedge clk) begin
    if (!reset_x) begin
      result.valid   <= 1'b0;
      redirect.valid <= 1'b0;
    end else begin
      result.valid   <= do_csr;
      redirect.valid <= squash;
    end
    result.rd       <= req.rd;
    result.data     <= old_value;
    // direct mode only, base is word aligned
    redirect.target <= trap ? {mtvec[31:2], 2'b00} : mepc;
  end

  a_single_output: assert property (@(posedge clk) disable iff (!reset_x)
    !(result.valid && redirect.valid))
    else $error("result and redirect pulsed together");

  a_one_output_per_req: assert property (@(posedge clk) disable iff (!reset_x)
    req.valid |=> result.valid != redirect.valid)
    else $error("request did not produce exactly one output");

  a_trap_enters_m: assert property (@(posedge clk) disable iff (!reset_x)
    trap |=> redirect.valid && priv_mode == csr_pkg::priv_m)
    else $error("trap redirect without M mode");

endmodule

// ==== logic/csr_pkg.sv ====
// CSR addresses, mstatus fields, reset values, cause codes, enums and stage structs
package csr_pkg;

  // instruction encodings
  localparam logic [6:0]  opcode_system = 7'h73;
  localparam logic [31:0] instr_ecall   = 32'h0000_0073;
  localparam logic [31:0] instr_mret    = 32'h3020_0073;

  // machine-mode CSR addresses
  localparam logic [11:0] csr_addr_mstatus  = 12'h300;
  localparam logic [11:0] csr_addr_mie      = 12'h304;
  localparam logic [11:0] csr_addr_mtvec    = 12'h305;
  localparam logic [11:0] csr_addr_mscratch = 12'h340;
  localparam logic [11:0] csr_addr_mepc     = 12'h341;
  localparam logic [11:0] csr_addr_mcause   = 12'h342;
  localparam logic [11:0] csr_addr_mtval    = 12'h343;
  localparam logic [11:0] csr_addr_mip      = 12'h344;

  // mstatus bit positions, MPP occupies two bits from mpp_lo
  localparam int mstatus_mie    = 3;
  localparam int mstatus_mpie   = 7;
  localparam int mstatus_mpp_lo = 11;

  // MPP = M, MIE and MPIE clear
  localparam logic [31:0] mstatus_reset  = 32'h0000_1800;
  localparam logic [31:0] mscratch_reset = 32'h0802_0000;

  // exception cause codes
  localparam logic [3:0] cause_illegal = 4'd2;
  localparam logic [3:0] cause_ecall_u = 4'd8;
  localparam logic [3:0] cause_ecall_m = 4'd11;

  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_m = 2'b11
  } priv_e;

  typedef enum logic [2:0] {
    op_write,
    op_set,
    op_clear,
    op_ecall,
    op_mret,
    op_illegal
  } csr_op_e;

  // stage 1 to stage 2 request
  typedef struct packed {
    logic        valid;
    csr_op_e     op;
    logic [11:0] addr;
    logic [31:0] operand;
    logic        no_write;
    logic [4:0]  rd;
    logic [31:0] pc;
    logic [31:0] instr;
  } csr_req_t;

  // register writeback for a CSR op
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } csr_result_t;

  // fetch redirect for trap entry or mret
  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } csr_redirect_t;

endpackage

// ==== logic/csr_unit.sv ====
// top level of the two-stage CSR unit, decode then CSR file with its ALU
`timescale 1ns/1ps

module csr_unit (
  input  logic                   clk,
  input  logic                   reset_x,
  input  logic                   instr_valid,
  input  logic [31:0]            instr,
  input  logic [31:0]            pc,
  input  logic [31:0]            rs1_data,
  output csr_pkg::csr_result_t   result,
  output csr_pkg::csr_redirect_t redirect,
  output csr_pkg::priv_e         priv_mode
);

  csr_pkg::csr_req_t req;
  logic              squash;
  logic [31:0]       old_value;
  logic [31:0]       new_value;
  logic              write_en;

  // stage 1
  csr_decode u_decode (
    .clk         (clk),
    .reset_x     (reset_x),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .squash      (squash),
    .req         (req)
  );

  // modify path for the stage 2 commit
  csr_alu u_alu (
    .op        (req.op),
    .old_value (old_value),
    .operand   (req.operand),
    .no_write  (req.no_write),
    .new_value (new_value),
    .write_en  (write_en)
  );

  // stage 2
  csr_file u_file (
    .clk       (clk),
    .reset_x   (reset_x),
    .req       (req),
    .new_value (new_value),
    .write_en  (write_en),
    .old_value (old_value),
    .result    (result),
    .redirect  (redirect),
    .squash    (squash),
    .priv_mode (priv_mode)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build the CSR unit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f all.f \
  --top-module tb_csr_unit \
  -o sim_csr_unit \
  && ./obj_dir/sim_csr_unit | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tests/tb_clock.sv ====
// clock and reset generator for the CSR unit testbench
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset_x
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // reset held low for three rising edges
  initial begin
    reset_x = 1'b0;
    repeat (3) @(posedge clk);
    reset_x <= 1'b1;
  end

endmodule

// ==== tests/tb_csr_unit.sv ====
// testbench for the CSR unit with LCG stimulus, reference model and output checks
`timescale 1ns/1ps

module tb_csr_unit;

  typedef struct packed {
    logic        redirect;
    logic [4:0]  rd;
    logic [31:0] value;
    logic [1:0]  priv;
  } expect_t;

  logic                   clk;
  logic                   reset_x;
  logic                   instr_valid;
  logic [31:0]            instr;
  logic [31:0]            pc;
  logic [31:0]            rs1_data;
  csr_pkg::csr_result_t   result;
  csr_pkg::csr_redirect_t redirect;
  csr_pkg::priv_e         priv_mode;

  logic [31:0] seed;
  // mstatus, mie, mtvec, mscratch, mepc, mcause, mtval, mip
  logic [31:0] model_csr [8];
  logic [1:0]  model_priv;
  logic        squash_next;
  expect_t     exp_q [$];
  int          issued_count;
  int          seen_count;

  tb_clock u_clock (
    .clk     (clk),
    .reset_x (reset_x)
  );

  csr_unit u_csr_unit (
    .clk         (clk),
    .reset_x     (reset_x),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .result      (result),
    .redirect    (redirect),
    .priv_mode   (priv_mode)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [11:0] addr_of(input int i);
    case (i)
      0:       return 12'h300;
      1:       return 12'h304;
      2:       return 12'h305;
      3:       return 12'h340;
      4:       return 12'h341;
      5:       return 12'h342;
      6:       return 12'h343;
      default: return 12'h344;
    endcase
  endfunction

  function automatic int csr_index(input logic [11:0] a);
    int idx;
    idx = -1;
    for (int k = 0; k < 8; k++) begin
      if (addr_of(k) == a) idx = k;
    end
    return idx;
  endfunction

  function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [11:0] a,
                                           input logic [4:0] rs1f, input logic [4:0] rd);
    return {a, rs1f, f3, rd, 7'h73};
  endfunction

  // stage-2 rules applied to the model CSRs, returns the expected output
  function automatic expect_t ref_model(input logic [31:0] word, input logic [31:0] pc_v,
                                        input logic [31:0] rs1_v);
    expect_t     e;
    int          idx;
    logic [2:0]  f3;
    logic        csr_op;
    logic        is_ecall;
    logic        is_mret;
    logic        illegal;
    logic [31:0] operand;
    logic [31:0] old;
    logic [31:0] nv;
    logic [31:0] ms;
    logic [1:0]  mpp;
    f3       = word[14:12];
    idx      = csr_index(word[31:20]);
    csr_op   = word[6:0] == 7'h73 && f3 != 3'd0 && f3 != 3'd4 && idx >= 0;
    is_ecall = word == 32'h0000_0073;
    is_mret  = word == 32'h3020_0073;
    illegal  = !(csr_op || is_ecall || is_mret) || ((csr_op || is_mret) && model_priv == 2'b00);
    e  = '0;
    ms = model_csr[0];
    if (illegal || is_ecall) begin
      model_csr[4] = pc_v;
      if (illegal) begin
        model_csr[5] = 32'd2;
        model_csr[6] = word;
      end else if (model_priv == 2'b11) begin
        model_csr[5] = 32'd11;
      end else begin
        model_csr[5] = 32'd8;
      end
      ms[7]       = ms[3];
      ms[3]       = 1'b0;
      ms[12:11]   = model_priv;
      model_csr[0] = ms;
      model_priv  = 2'b11;
      e.redirect  = 1'b1;
      e.value     = {model_csr[2][31:2], 2'b00};
    end else if (is_mret) begin
      mpp          = ms[12:11];
      ms[3]        = ms[7];
      ms[7]        = 1'b1;
      ms[12:11]    = 2'b00;
      model_csr[0] = ms;
      model_priv   = mpp;
      e.redirect   = 1'b1;
      e.value      = model_csr[4];
    end else begin
      operand = f3[2] ? {27'd0, word[19:15]} : rs1_v;
      old     = model_csr[idx];
      case (f3[1:0])
        2'b01:   nv = operand;
        2'b10:   nv = old | operand;
        default: nv = old & ~operand;
      endcase
      // set and clear with rs1 field 0 only read
      if (f3[1:0] == 2'b01 || word[19:15] != 5'd0) model_csr[idx] = nv;
      e.rd    = word[11:7];
      e.value = old;
    end
    e.priv = model_priv;
    return e;
  endfunction

  task automatic stop_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic issue(input logic [31:0] word, input logic [31:0] pc_v,
                       input logic [31:0] rs1_v);
    expect_t e;
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= word;
    pc          <= pc_v;
    rs1_data    <= rs1_v;
    // the strobe right behind a redirect is dropped by the DUT
    if (squash_next) begin
      squash_next = 1'b0;
    end else begin
      e = ref_model(word, pc_v, rs1_v);
      exp_q.push_back(e);
      issued_count++;
      squash_next = e.redirect;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      instr_valid <= 1'b0;
    end
    squash_next = 1'b0;
  endtask

  task automatic read_csr(input int i);
    issue(csr_word(3'b010, addr_of(i), 5'd0, 5'd1), 32'h0000_0800, 32'hffff_ffff);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timed out waiting for %0d outstanding outputs", exp_q.size());
      stop_run();
    end
  endtask

  // outputs settle after the rising edge, sampled on the falling edge
  always @(negedge clk) begin : monitor
    expect_t e;
    if (reset_x && (result.valid || redirect.valid)) begin
      if (exp_q.size() == 0) begin
        $display("DUT produced an output with nothing outstanding at %0t", $time);
        stop_run();
      end else begin
        e = exp_q.pop_front();
        seen_count++;
        compare("redirect.valid", 32'(redirect.valid), 32'(e.redirect));
        compare("result.valid", 32'(result.valid), 32'(!e.redirect));
        if (e.redirect) begin
          compare("redirect.target", redirect.target, e.value);
        end else begin
          compare("result.rd", 32'(result.rd), 32'(e.rd));
          compare("result.data", result.data, e.value);
        end
        compare("priv_mode", 32'(priv_mode), 32'(e.priv));
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] word;
    int          sel;
    int          n;
    instr_valid  = 1'b0;
    instr        = 32'd0;
    pc           = 32'd0;
    rs1_data     = 32'd0;
    seed         = 32'h3f04;
    squash_next  = 1'b0;
    issued_count = 0;
    seen_count   = 0;
    for (int i = 0; i < 8; i++) model_csr[i] = 32'd0;
    model_csr[0] = 32'h0000_1800;
    model_csr[3] = 32'h0802_0000;
    model_priv   = 2'b11;

    n = 0;
    while (!reset_x && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (!reset_x) begin
      $display("reset was never released");
      stop_run();
    end

    // reset values through csrrs with rs1 = x0
    for (int i = 0; i < 8; i++) begin
      issue(csr_word(3'b010, addr_of(i), 5'd0, 5'(i + 1)), 32'h0000_0040, next_rand());
    end
    idle(1);
    drain();

    // random write, set and clear, back to back
    for (int k = 0; k < 200; k++) begin
      r   = next_rand();
      sel = int'(r[10:8]) % 6;
      word = csr_word(3'(sel < 3 ? sel + 1 : sel + 2), addr_of(int'(r[18:16])),
                      r[23:19], r[28:24]);
      issue(word, 32'h0000_1000 + 32'(k * 4), next_rand());
    end
    for (int i = 0; i < 8; i++) read_csr(i);
    idle(1);
    drain();

    // ecall in M mode with a misaligned mtvec and MIE set
    issue(csr_word(3'b001, 12'h305, 5'd1, 5'd0), 32'h0000_00f8, 32'h0000_1003);
    issue(csr_word(3'b001, 12'h300, 5'd2, 5'd0), 32'h0000_00fc, 32'h0000_1808);
    issue(32'h0000_0073, 32'h0000_0100, 32'd0);
    compare("ecall target", exp_q[$].value, 32'h0000_1000);
    issue(csr_word(3'b001, 12'h340, 5'd5, 5'd2), 32'h0000_0104, 32'h5555_aaaa);
    idle(1);
    compare("model mcause", model_csr[5], 32'd11);
    compare("model mstatus", model_csr[0], 32'h0000_1880);
    read_csr(4);
    read_csr(5);
    read_csr(0);
    read_csr(3);
    idle(1);
    drain();

    // mret into U mode, then ecall from U
    issue(csr_word(3'b011, 12'h300, 5'd7, 5'd0), 32'h0000_0200, 32'h0000_1800);
    issue(csr_word(3'b001, 12'h341, 5'd8, 5'd0), 32'h0000_0204, 32'h0000_0400);
    issue(32'h3020_0073, 32'h0000_0208, 32'd0);
    idle(1);
    compare("model priv", 32'(model_priv), 32'd0);
    issue(32'h0000_0073, 32'h0000_0400, 32'd0);
    idle(1);
    compare("model mcause", model_csr[5], 32'd8);
    read_csr(5);
    read_csr(0);
    idle(1);
    drain();

    // CSR access from U mode
    issue(csr_word(3'b011, 12'h300, 5'd7, 5'd0), 32'h0000_0500, 32'h0000_1800);
    issue(csr_word(3'b001, 12'h341, 5'd8, 5'd0), 32'h0000_0504, 32'h0000_0600);
    issue(32'h3020_0073, 32'h0000_0508, 32'd0);
    idle(1);
    word = csr_word(3'b001, 12'h340, 5'd9, 5'd4);
    issue(word, 32'h0000_0600, 32'hdead_beef);
    idle(1);
    compare("model mtval", model_csr[6], word);
    read_csr(3);
    read_csr(5);
    read_csr(6);
    idle(1);
    drain();

    // unknown address, then a bad funct3
    word = csr_word(3'b001, 12'h7c0, 5'd4, 5'd3);
    issue(word, 32'h0000_0700, 32'h1234_5678);
    idle(1);
    compare("model mtval", model_csr[6], word);
    read_csr(5);
    read_csr(6);
    word = csr_word(3'b100, 12'h340, 5'd3, 5'd3);
    issue(word, 32'h0000_0704, 32'h8765_4321);
    idle(1);
    compare("model mcause", model_csr[5], 32'd2);
    read_csr(3);
    read_csr(6);
    idle(2);
    drain();
    idle(4);

    if (exp_q.size() == 0 && seen_count == issued_count) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("saw %0d outputs for %0d expected", seen_count, issued_count);
      stop_run();
    end
  end

endmodule
